//--- hdl/key_event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module key_event_fifo (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input ps2_kbd_pkg::key_event_t din,
	input logic credit_return, // one pulse per freed consumer slot
	output ps2_kbd_pkg::key_event_t ev_out,
	output logic ev_send,
	output logic overflow
);

	ps2_kbd_pkg::key_event_t mem [ps2_kbd_pkg::FIFO_DEPTH];
	logic [ps2_kbd_pkg::FIFO_PTR_W-1:0] wr_ptr, rd_ptr; // wrap at depth
	logic [ps2_kbd_pkg::FIFO_CNT_W-1:0] count;
	logic [ps2_kbd_pkg::CREDIT_W-1:0] credits;
	logic full, push, pop;

	assign full = (count == ps2_kbd_pkg::FIFO_FULL);
	assign push = wr && !full; // keyboard can't be held off, so drop
	assign pop = (count != '0) && (credits != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= ps2_kbd_pkg::CREDIT_MAX;
			ev_send <= 1'b0;
			overflow <= 1'b0;
		end else begin
			ev_send <= pop;
			overflow <= wr && full;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither
			endcase
			case ({credit_return, pop})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: ; // send and return cancel
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din;
		if (pop)
			ev_out <= mem[rd_ptr]; // held until next send
	end

endmodule

`default_nettype wire

//--- hdl/ps2_bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_bit_timer (
	input logic clk,
	input logic rst_n,
	input logic fall, // ps2 clock fall, already synchronized
	input logic in_frame, // receiver is mid-frame
	output logic stall
);

	logic [ps2_kbd_pkg::TIMER_W-1:0] cnt; // cycles since last fall

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			stall <= 1'b0;
		end else begin
			stall <= 1'b0;
			if (fall) begin
				cnt <= '0; // every bit restarts the window
			end else if (in_frame && cnt != ps2_kbd_pkg::TIMEOUT_CYCLES) begin
				cnt <= cnt + 1'b1;
				// single pulse as the count lands on the limit
				stall <= (cnt == ps2_kbd_pkg::TIMEOUT_CYCLES - 1'b1);
			end
			// at the limit cnt sits still until the next fall
		end
	end

endmodule

`default_nettype wire

//--- hdl/ps2_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx (
	input logic clk,
	input logic rst_n,
	input logic ps2_clk_in, // async, idle high
	input logic ps2_data_in, // async, idle high
	input logic stall, // from bit timer
	output logic fall,
	output logic in_frame,
	output ps2_kbd_pkg::rx_byte_t rx_byte,
	output logic frame_err
);

	logic clk_s0, clk_s1, clk_s2; // s0/s1 synchronizer, s2 edge history
	logic dat_s0, dat_s1;
	logic [ps2_kbd_pkg::BIT_IDX_W-1:0] idx; // bits taken so far
	logic [ps2_kbd_pkg::FRAME_BITS-1:0] shreg;
	logic [ps2_kbd_pkg::FRAME_BITS-1:0] frame; // shreg with the current bit shifted in
	ps2_kbd_pkg::frame_status_t status;
	logic rx_valid;
	logic [7:0] rx_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clk_s0 <= 1'b1; // lines idle high
			clk_s1 <= 1'b1;
			clk_s2 <= 1'b1;
			dat_s0 <= 1'b1;
			dat_s1 <= 1'b1;
		end else begin
			clk_s0 <= ps2_clk_in;
			clk_s1 <= clk_s0;
			clk_s2 <= clk_s1;
			dat_s0 <= ps2_data_in;
			dat_s1 <= dat_s0;
		end
	end

	assign fall = clk_s2 & ~clk_s1; // two cycles after the pin edge
	assign in_frame = (idx != '0);

	// lsb first on the wire, so shift in from the top
	assign frame = {dat_s1, shreg[ps2_kbd_pkg::FRAME_BITS-1:1]};

	always_comb begin
		if (frame[0] != 1'b0)
			status = ps2_kbd_pkg::FRAME_BAD_START;
		else if (frame[10] != 1'b1)
			status = ps2_kbd_pkg::FRAME_BAD_STOP;
		else if (^frame[9:1] != 1'b1) // odd parity over data + parity bit
			status = ps2_kbd_pkg::FRAME_BAD_PARITY;
		else
			status = ps2_kbd_pkg::FRAME_OK;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx <= '0;
			rx_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			frame_err <= 1'b0;
			if (stall) begin
				idx <= '0; // partial frame dropped, no error flagged
			end else if (fall) begin
				if (idx == ps2_kbd_pkg::FRAME_LAST) begin
					idx <= '0;
					rx_valid <= (status == ps2_kbd_pkg::FRAME_OK);
					frame_err <= (status != ps2_kbd_pkg::FRAME_OK);
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fall)
			shreg <= frame;
		if (fall && idx == ps2_kbd_pkg::FRAME_LAST)
			rx_data <= frame[8:1]; // data bits only
	end

	assign rx_byte = '{valid: rx_valid, data: rx_data};

endmodule

`default_nettype wire

//--- hdl/ps2_kbd_pkg.sv
`default_nettype none

package ps2_kbd_pkg;

	// bit timer
	localparam int TIMER_W = 13;
	localparam logic [TIMER_W-1:0] TIMEOUT_CYCLES = 13'd4096; // ~82 us at 50 MHz

	// frame layout: start, 8 data, parity, stop
	localparam int FRAME_BITS = 11;
	localparam int BIT_IDX_W = 4;
	localparam logic [BIT_IDX_W-1:0] FRAME_LAST = 4'd10; // index of stop bit

	// event fifo and credit loop
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2;
	localparam int FIFO_CNT_W = 3;
	localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = 3'd4;
	localparam int CREDIT_W = 3;
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = 3'd4; // consumer buffer slots

	// set 2 codes with special meaning
	localparam logic [7:0] CODE_E0 = 8'hE0; // extended prefix
	localparam logic [7:0] CODE_F0 = 8'hF0; // break prefix
	localparam logic [7:0] CODE_LSHIFT = 8'h12;
	localparam logic [7:0] CODE_RSHIFT = 8'h59;
	localparam logic [7:0] CODE_CAPS = 8'h58;

	typedef struct packed {
		logic [7:0] scan;
		logic [7:0] ascii; // zero if no printable mapping
		logic extended;
		logic released;
		logic shift; // modifier state before this key
		logic caps;
	} key_event_t;

	typedef struct packed {
		logic valid; // one-cycle strobe
		logic [7:0] data;
	} rx_byte_t;

	// result of the frame check, first failing field wins
	typedef enum logic [1:0] {
		FRAME_OK,
		FRAME_BAD_START,
		FRAME_BAD_STOP,
		FRAME_BAD_PARITY
	} frame_status_t;

endpackage

`default_nettype wire

//--- hdl/ps2_keyboard_top.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_top (
	input logic clk,
	input logic rst_n,
	input logic ps2_clk_in,
	input logic ps2_data_in,
	input logic credit_return,
	output ps2_kbd_pkg::key_event_t ev_out,
	output logic ev_send,
	output logic overflow,
	output logic frame_err
);

	logic fall, in_frame, stall;
	ps2_kbd_pkg::rx_byte_t rx_byte;
	logic [7:0] scan_q, ascii;
	logic ext_q, shift_q, caps_q;
	ps2_kbd_pkg::key_event_t ev;
	logic ev_stb;

	ps2_frame_rx u_frame_rx (
		.clk(clk), .rst_n(rst_n),
		.ps2_clk_in(ps2_clk_in), .ps2_data_in(ps2_data_in),
		.stall(stall), .fall(fall), .in_frame(in_frame),
		.rx_byte(rx_byte), .frame_err(frame_err)
	);

	ps2_bit_timer u_bit_timer (
		.clk(clk), .rst_n(rst_n),
		.fall(fall), .in_frame(in_frame), .stall(stall)
	);

	scan_code_fsm u_scan_fsm (
		.clk(clk), .rst_n(rst_n),
		.rx_byte(rx_byte), .ascii(ascii),
		.scan_q(scan_q), .ext_q(ext_q), .shift_q(shift_q), .caps_q(caps_q),
		.ev(ev), .ev_stb(ev_stb)
	);

	// table sits beside the fsm, looks up the held final byte
	scan_to_ascii u_ascii (
		.scan(scan_q), .extended(ext_q), .shift(shift_q), .caps(caps_q),
		.ascii(ascii)
	);

	key_event_fifo u_fifo (
		.clk(clk), .rst_n(rst_n),
		.wr(ev_stb), .din(ev), .credit_return(credit_return),
		.ev_out(ev_out), .ev_send(ev_send), .overflow(overflow)
	);

endmodule

`default_nettype wire

//--- hdl/scan_code_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module scan_code_fsm (
	input logic clk,
	input logic rst_n,
	input ps2_kbd_pkg::rx_byte_t rx_byte,
	input logic [7:0] ascii, // from table, looked up on scan_q
	output logic [7:0] scan_q,
	output logic ext_q,
	output logic shift_q,
	output logic caps_q,
	output ps2_kbd_pkg::key_event_t ev,
	output logic ev_stb
);

	typedef enum logic [1:0] {
		IDLE,
		GOT_E0,
		GOT_F0,
		GOT_E0F0
	} state_t;

	state_t state, state_nxt;
	logic final_byte; // byte closes a key sequence
	logic ext, brk; // prefixes seen so far
	logic is_shift, is_caps;
	logic shift, caps; // live modifier state
	logic rel_q;

	assign ext = (state == GOT_E0) || (state == GOT_E0F0);
	assign brk = (state == GOT_F0) || (state == GOT_E0F0);
	assign is_shift = (rx_byte.data == ps2_kbd_pkg::CODE_LSHIFT)
		|| (rx_byte.data == ps2_kbd_pkg::CODE_RSHIFT);
	assign is_caps = (rx_byte.data == ps2_kbd_pkg::CODE_CAPS);

	always_comb begin
		state_nxt = state;
		final_byte = 1'b0;
		case (state)
			IDLE: begin
				if (rx_byte.data == ps2_kbd_pkg::CODE_E0)
					state_nxt = GOT_E0;
				else if (rx_byte.data == ps2_kbd_pkg::CODE_F0)
					state_nxt = GOT_F0;
				else
					final_byte = 1'b1;
			end
			GOT_E0: begin
				if (rx_byte.data == ps2_kbd_pkg::CODE_F0)
					state_nxt = GOT_E0F0;
				else
					final_byte = 1'b1;
			end
			default: final_byte = 1'b1; // both F0 states end on the next byte
		endcase
		if (final_byte)
			state_nxt = IDLE;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			shift <= 1'b0;
			caps <= 1'b0;
			ev_stb <= 1'b0;
		end else begin
			ev_stb <= rx_byte.valid && final_byte;
			if (rx_byte.valid) begin
				state <= state_nxt;
				// E0 12 / E0 59 are fake shifts, ignored
				if (final_byte && !ext && is_shift)
					shift <= !brk;
				if (final_byte && !ext && !brk && is_caps)
					caps <= !caps; // toggles on make only
			end
		end
	end

	// event fields, modifiers captured before this byte updates them
	always_ff @(posedge clk) begin
		if (rx_byte.valid && final_byte) begin
			scan_q <= rx_byte.data;
			ext_q <= ext;
			rel_q <= brk;
			shift_q <= shift;
			caps_q <= caps;
		end
	end

	assign ev = '{scan: scan_q, ascii: ascii, extended: ext_q, released: rel_q,
		shift: shift_q, caps: caps_q};

endmodule

`default_nettype wire

//--- hdl/scan_to_ascii.sv
`timescale 1ns/1ps
`default_nettype none

module scan_to_ascii (
	input logic [7:0] scan,
	input logic extended,
	input logic shift,
	input logic caps,
	output logic [7:0] ascii
);

	logic [7:0] letter; // lower case letter, zero if not a letter
	logic [15:0] pair; // {shifted, plain}

	always_comb begin
		case (scan)
			8'h1C: letter = "a";
			8'h32: letter = "b";
			8'h21: letter = "c";
			8'h23: letter = "d";
			8'h24: letter = "e";
			8'h2B: letter = "f";
			8'h34: letter = "g";
			8'h33: letter = "h";
			8'h43: letter = "i";
			8'h3B: letter = "j";
			8'h42: letter = "k";
			8'h4B: letter = "l";
			8'h3A: letter = "m";
			8'h31: letter = "n";
			8'h44: letter = "o";
			8'h4D: letter = "p";
			8'h15: letter = "q";
			8'h2D: letter = "r";
			8'h1B: letter = "s";
			8'h2C: letter = "t";
			8'h3C: letter = "u";
			8'h2A: letter = "v";
			8'h1D: letter = "w";
			8'h22: letter = "x";
			8'h35: letter = "y";
			8'h1A: letter = "z";
			default: letter = 8'h00;
		endcase
	end

	always_comb begin
		case (scan)
			8'h16: pair = "!1";
			8'h1E: pair = "@2";
			8'h26: pair = "#3";
			8'h25: pair = "$4";
			8'h2E: pair = "%5";
			8'h36: pair = "^6";
			8'h3D: pair = "&7";
			8'h3E: pair = "*8";
			8'h46: pair = "(9";
			8'h45: pair = ")0";
			8'h0E: pair = {8'h7E, 8'h60}; // ~ `
			8'h4E: pair = "_-";
			8'h55: pair = "+=";
			8'h54: pair = "{[";
			8'h5B: pair = "}]";
			8'h5D: pair = {8'h7C, 8'h5C}; // | backslash
			8'h4C: pair = ":;";
			8'h52: pair = {8'h22, 8'h27}; // double and single quote
			8'h41: pair = "<,";
			8'h49: pair = ">.";
			8'h4A: pair = "?/";
			8'h29: pair = {8'h20, 8'h20}; // space, same either way
			8'h66: pair = {8'h08, 8'h08}; // backspace
			8'h5A: pair = {8'h0D, 8'h0D}; // enter
			8'h76: pair = {8'h1B, 8'h1B}; // escape
			default: pair = 16'h0000;
		endcase
	end

	always_comb begin
		if (extended)
			ascii = 8'h00; // arrows, keypad enter etc. have no text
		else if (letter != 8'h00)
			ascii = (shift ^ caps) ? letter - 8'h20 : letter; // caps flips letters only
		else
			ascii = shift ? pair[15:8] : pair[7:0];
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the PS/2 keyboard testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_ps2_keyboard -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- src.f
+incdir+include
hdl/ps2_kbd_pkg.sv
hdl/ps2_bit_timer.sv
hdl/ps2_frame_rx.sv
hdl/scan_code_fsm.sv
hdl/scan_to_ascii.sv
hdl/key_event_fifo.sv
hdl/ps2_keyboard_top.sv
test/tb_ps2_keyboard.sv

//--- include/ps2_tb_host.svh
`ifndef PS2_TB_HOST_SVH
`define PS2_TB_HOST_SVH

localparam int PS2_HALF = 30; // clk cycles per PS/2 half period

// first error ends the run
task automatic stop_on_error();
	$display("** FAIL **");
	$fatal(1, "stopped at first error");
endtask

task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act) begin
		$display("error %s: expected %0h, actual %0h", name, exp, act);
		stop_on_error();
	end
endtask

// 32-bit lcg, numerical recipes constants
function automatic logic [31:0] next_rand(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// one bit cell: data set mid-high, clock low for a half period
task automatic drive_bit(input logic b);
	@(posedge clk);
	ps2_data <= b;
	repeat (PS2_HALF / 2) @(posedge clk);
	ps2_clk <= 1'b0; // receiver samples on this fall
	repeat (PS2_HALF) @(posedge clk);
	ps2_clk <= 1'b1;
	repeat (PS2_HALF - PS2_HALF / 2) @(posedge clk);
endtask

// bad: 0 good, 1 parity flipped, 2 start high, 3 stop low
task automatic send_frame(input logic [7:0] data, input logic [1:0] bad, input int nbits);
	logic [10:0] bits;
	bits = {bad != 2'd3, (~^data) ^ (bad == 2'd1), data, bad == 2'd2};
	for (int i = 0; i < nbits; i++)
		drive_bit(bits[i]); // lsb first, start bit leads
	@(posedge clk);
	ps2_data <= 1'b1; // line back to idle
endtask

// sample at negedge, away from the dut's update edge
task automatic wait_events(input int n, input int limit);
	int t;
	t = 0;
	while (got_q.size() < n && t < limit) begin
		@(negedge clk);
		t++;
	end
	if (got_q.size() < n) begin
		$display("timeout waiting for key events: wanted %0d, have %0d", n, got_q.size());
		stop_on_error();
	end
endtask

// consumer has handed every credit back
task automatic wait_credits_returned(input int limit);
	int t;
	t = 0;
	while (owed > 0 && t < limit) begin
		@(negedge clk);
		t++;
	end
	if (owed > 0) begin
		$display("timeout waiting for credits to return: %0d still held", owed);
		stop_on_error();
	end
endtask

`endif

//--- test/tb_ps2_keyboard.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keyboard;

	typedef struct packed {
		logic [23:0] bytes; // sent high byte first
		logic [1:0] nbytes; // 0 = frame cut after five bits
		logic [1:0] bad; // corruption kind
		logic expect_ev;
		logic [7:0] scan;
		logic ext, rel, shift, caps; // expected event flags
	} vec_t;

	localparam int NVEC = 29;
	localparam int CMAX = int'(ps2_kbd_pkg::CREDIT_MAX);
	localparam int DEPTH = ps2_kbd_pkg::FIFO_DEPTH;

	// set 2 letter codes, a to z
	localparam logic [7:0] LETTER_SC [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
		8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15,
		8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
	// digit and symbol keys, same order as the two strings below
	localparam logic [7:0] SYM_SC [21] = '{8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
		8'h3D, 8'h3E, 8'h46, 8'h45, 8'h0E, 8'h4E, 8'h55, 8'h54, 8'h5B, 8'h5D, 8'h4C,
		8'h52, 8'h41, 8'h49, 8'h4A};
	localparam string SYM_PLAIN = "1234567890`-=[]\\;',./";
	localparam string SYM_SHIFT = "!@#$%^&*()~_+{}|:\"<>?";

	localparam vec_t VECS [NVEC] = '{
		{24'h00001C, 2'd1, 2'd0, 1'b1, 8'h1C, 4'b0000}, // a
		{24'h000012, 2'd1, 2'd0, 1'b1, 8'h12, 4'b0000}, // left shift make
		{24'h00001C, 2'd1, 2'd0, 1'b1, 8'h1C, 4'b0010}, // A
		{24'h000016, 2'd1, 2'd0, 1'b1, 8'h16, 4'b0010}, // !
		{24'h00F012, 2'd2, 2'd0, 1'b1, 8'h12, 4'b0110}, // shift break
		{24'h000016, 2'd1, 2'd0, 1'b1, 8'h16, 4'b0000}, // 1
		{24'h000058, 2'd1, 2'd0, 1'b1, 8'h58, 4'b0000}, // caps on
		{24'h00F058, 2'd2, 2'd0, 1'b1, 8'h58, 4'b0101},
		{24'h00001C, 2'd1, 2'd0, 1'b1, 8'h1C, 4'b0001}, // A via caps
		{24'h000059, 2'd1, 2'd0, 1'b1, 8'h59, 4'b0001}, // right shift make
		{24'h00001C, 2'd1, 2'd0, 1'b1, 8'h1C, 4'b0011}, // shift and caps cancel
		{24'h00004E, 2'd1, 2'd0, 1'b1, 8'h4E, 4'b0011}, // _ ignores caps
		{24'h00F059, 2'd2, 2'd0, 1'b1, 8'h59, 4'b0111},
		{24'h000058, 2'd1, 2'd0, 1'b1, 8'h58, 4'b0001}, // caps off
		{24'h00F058, 2'd2, 2'd0, 1'b1, 8'h58, 4'b0100},
		{24'h00E075, 2'd2, 2'd0, 1'b1, 8'h75, 4'b1000}, // up arrow
		{24'hE0F075, 2'd3, 2'd0, 1'b1, 8'h75, 4'b1100},
		{24'h00E012, 2'd2, 2'd0, 1'b1, 8'h12, 4'b1000}, // fake shift
		{24'h00001C, 2'd1, 2'd0, 1'b1, 8'h1C, 4'b0000}, // still lower case
		{24'h00F01C, 2'd2, 2'd0, 1'b1, 8'h1C, 4'b0100},
		{24'h000029, 2'd1, 2'd1, 1'b0, 8'h00, 4'b0000}, // bad parity
		{24'h000029, 2'd1, 2'd2, 1'b0, 8'h00, 4'b0000}, // bad start
		{24'h000029, 2'd1, 2'd3, 1'b0, 8'h00, 4'b0000}, // bad stop
		{24'h000029, 2'd1, 2'd0, 1'b1, 8'h29, 4'b0000}, // space
		{24'h00001C, 2'd0, 2'd0, 1'b0, 8'h00, 4'b0000}, // stalled frame
		{24'h00005A, 2'd1, 2'd0, 1'b1, 8'h5A, 4'b0000}, // enter
		{24'h000076, 2'd1, 2'd0, 1'b1, 8'h76, 4'b0000}, // escape
		{24'h000066, 2'd1, 2'd0, 1'b1, 8'h66, 4'b0000}, // backspace
		{24'h000052, 2'd1, 2'd0, 1'b1, 8'h52, 4'b0000} // quote
	};

	logic clk, rst_n, ps2_clk, ps2_data;
	logic credit_return = 1'b0;
	ps2_kbd_pkg::key_event_t ev_out;
	logic ev_send, overflow, frame_err;
	ps2_kbd_pkg::key_event_t got_q [$]; // events seen by the consumer
	int owed = 0; // events held, credit not yet returned
	int delay = 0;
	int err_cnt = 0;
	int ovf_cnt = 0;
	logic hold = 1'b0; // withhold all credits
	logic rand_mode = 1'b0; // random return delay
	logic [31:0] rnd = 32'h793f_b714;

	`include "ps2_tb_host.svh"

	ps2_keyboard_top u_dut (
		.clk(clk), .rst_n(rst_n),
		.ps2_clk_in(ps2_clk), .ps2_data_in(ps2_data),
		.credit_return(credit_return),
		.ev_out(ev_out), .ev_send(ev_send), .overflow(overflow), .frame_err(frame_err)
	);

	// ascii from the key map rules
	function automatic logic [7:0] ref_ascii(input logic [7:0] sc, input logic ext,
		input logic sh, input logic cp);
		logic [7:0] res;
		res = 8'h00;
		for (int i = 0; i < 26; i++)
			if (LETTER_SC[i] == sc)
				res = ((sh ^ cp) ? 8'h41 : 8'h61) + 8'(i); // caps flips letters
		for (int i = 0; i < 21; i++)
			if (SYM_SC[i] == sc)
				res = sh ? SYM_SHIFT[i] : SYM_PLAIN[i];
		case (sc)
			8'h29: res = 8'h20;
			8'h66: res = 8'h08;
			8'h5A: res = 8'h0D;
			8'h76: res = 8'h1B;
			default: ;
		endcase
		return ext ? 8'h00 : res;
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// consumer: takes events, hands credits back
	always @(posedge clk) begin
		credit_return <= 1'b0;
		if (frame_err)
			err_cnt++;
		if (overflow)
			ovf_cnt++;
		if (ev_send) begin
			got_q.push_back(ev_out);
			owed++;
		end
		if (owed > CMAX) begin
			$display("more than %0d events outstanding at the consumer", CMAX);
			stop_on_error();
		end
		if (delay > 0) begin
			delay--;
		end else if (owed > 0 && !hold) begin
			credit_return <= 1'b1;
			owed--;
			rnd = next_rand(rnd);
			delay = rand_mode ? int'(rnd[18:16]) : 0; // up to 7 idle cycles
		end
	end

	initial begin
		vec_t v;
		string name;
		int base, errs, ovf;
		rst_n = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (5) @(posedge clk);

		for (int i = 0; i < NVEC; i++) begin
			v = VECS[i];
			name = $sformatf("vec%0d", i);
			base = got_q.size();
			errs = err_cnt;
			if (v.nbytes == 2'd0) begin
				send_frame(v.bytes[7:0], 2'd0, 5);
				repeat (int'(ps2_kbd_pkg::TIMEOUT_CYCLES) + 100) @(posedge clk);
			end else begin
				for (int k = int'(v.nbytes) - 1; k >= 0; k--)
					send_frame(v.bytes[8*k +: 8], v.bad, 11);
			end
			if (v.expect_ev) begin
				wait_events(base + 1, 200);
				check({name, " scan"}, 32'(v.scan), 32'(got_q[base].scan));
				check({name, " ascii"}, 32'(ref_ascii(v.scan, v.ext, v.shift, v.caps)),
					32'(got_q[base].ascii));
				check({name, " flags"}, 32'({v.ext, v.rel, v.shift, v.caps}),
					32'({got_q[base].extended, got_q[base].released,
					got_q[base].shift, got_q[base].caps}));
			end
			repeat (10) @(negedge clk); // past the 4 cycle latency
			check({name, " events"}, 32'(base + int'(v.expect_ev)), 32'(got_q.size()));
			check({name, " frame_err"}, 32'(errs + int'(v.bad != 2'd0)), 32'(err_cnt));
		end

		// credits withheld, only CMAX go out
		hold = 1'b1;
		base = got_q.size();
		for (int i = 0; i < 6; i++)
			send_frame(LETTER_SC[i], 2'd0, 11);
		wait_events(base + CMAX, 400);
		repeat (50) @(negedge clk);
		check("held sends", 32'(base + CMAX), 32'(got_q.size()));
		rand_mode = 1'b1;
		hold = 1'b0;
		wait_events(base + 6, 2000);
		for (int i = 0; i < 6; i++) begin
			check($sformatf("hold order %0d", i), 32'(LETTER_SC[i]), 32'(got_q[base + i].scan));
			check($sformatf("hold ascii %0d", i), 32'(ref_ascii(LETTER_SC[i], 0, 0, 0)),
				32'(got_q[base + i].ascii));
		end

		// overrun the fifo with no credits
		wait_credits_returned(200);
		rand_mode = 1'b0;
		hold = 1'b1;
		base = got_q.size();
		ovf = ovf_cnt;
		for (int i = 0; i < CMAX + DEPTH + 1; i++)
			send_frame(LETTER_SC[i], 2'd0, 11);
		repeat (20) @(negedge clk);
		check("overflow pulses", 32'(ovf + 1), 32'(ovf_cnt));
		check("sends before return", 32'(base + CMAX), 32'(got_q.size()));
		hold = 1'b0;
		wait_events(base + CMAX + DEPTH, 500);
		repeat (50) @(negedge clk);
		check("drained events", 32'(base + CMAX + DEPTH), 32'(got_q.size()));
		for (int i = 0; i < CMAX + DEPTH; i++)
			check($sformatf("drain order %0d", i), 32'(LETTER_SC[i]), 32'(got_q[base + i].scan));

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
